//--- hw/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// instruction queue entries
`define FE_BUF_DEPTH 16

// credits held after reset
`define FE_IMEM_CREDITS 4
`define FE_DEC_CREDITS 4

// first fetch address out of reset
`define FE_RESET_PC 32'h0000_1000

`endif

//--- hw/fe_ctrl_pkg.sv
package fe_ctrl_pkg;

    // buffer occupancy, 0 to 16
    typedef logic [4:0] fill_t;

    // instructions moved per cycle, 0 to 2
    typedef logic [1:0] slot_cnt_t;

    // credits and outstanding request counts
    typedef logic [2:0] credit_t;

    // queue index into the instruction buffer
    typedef logic [3:0] buf_ptr_t;

    // index into the outstanding request record
    typedef logic [1:0] req_ptr_t;

endpackage

//--- hw/fe_inst_pkg.sv
package fe_inst_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;

    localparam logic [6:0] OPC_JAL = 7'b1101111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // J immediate is stored scrambled, bit 0 is implied zero
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage

//--- hw/fetch_buffer.sv
`include "fe_consts.svh"

module fetch_buffer (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   redirect_valid,
    input  fe_ctrl_pkg::slot_cnt_t push_cnt,
    input  fe_inst_pkg::inst_t     push_inst0,
    input  fe_inst_pkg::inst_t     push_inst1,
    input  fe_inst_pkg::addr_t     push_pc0,
    input  fe_inst_pkg::addr_t     push_pc1,
    input  fe_ctrl_pkg::slot_cnt_t pop_cnt,
    output fe_inst_pkg::inst_t     head_inst0,
    output fe_inst_pkg::inst_t     head_inst1,
    output fe_inst_pkg::addr_t     head_pc0,
    output fe_inst_pkg::addr_t     head_pc1,
    output fe_ctrl_pkg::fill_t     fill
);

    fe_inst_pkg::inst_t    mem_inst [`FE_BUF_DEPTH];
    fe_inst_pkg::addr_t    mem_pc   [`FE_BUF_DEPTH];
    fe_ctrl_pkg::buf_ptr_t head_ptr;
    fe_ctrl_pkg::buf_ptr_t tail_ptr;
    fe_ctrl_pkg::buf_ptr_t head_nxt;
    fe_ctrl_pkg::buf_ptr_t tail_nxt;

    // pointers wrap naturally at the queue depth
    assign head_nxt = head_ptr + fe_ctrl_pkg::buf_ptr_t'(1);
    assign tail_nxt = tail_ptr + fe_ctrl_pkg::buf_ptr_t'(1);

    // oldest entry on slot 0
    assign head_inst0 = mem_inst[head_ptr];
    assign head_pc0   = mem_pc[head_ptr];
    assign head_inst1 = mem_inst[head_nxt];
    assign head_pc1   = mem_pc[head_nxt];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            fill     <= '0;
        end else if (redirect_valid) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            fill     <= '0;
        end else begin
            head_ptr <= head_ptr + fe_ctrl_pkg::buf_ptr_t'(pop_cnt);
            tail_ptr <= tail_ptr + fe_ctrl_pkg::buf_ptr_t'(push_cnt);
            fill     <= fill + fe_ctrl_pkg::fill_t'(push_cnt) - fe_ctrl_pkg::fill_t'(pop_cnt);
        end
    end

    // space is reserved upstream, so writes never hit live entries
    always_ff @(posedge clk) begin
        if (push_cnt != '0) begin
            mem_inst[tail_ptr] <= push_inst0;
            mem_pc[tail_ptr]   <= push_pc0;
        end
        if (push_cnt == 2'd2) begin
            mem_inst[tail_nxt] <= push_inst1;
            mem_pc[tail_nxt]   <= push_pc1;
        end
    end

endmodule

//--- hw/fetch_frontend.sv
module fetch_frontend (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   redirect_valid,
    input  fe_inst_pkg::addr_t     redirect_pc,
    output logic                   imem_req,
    output fe_inst_pkg::addr_t     imem_addr,
    input  logic                   imem_credit,
    input  logic                   imem_rsp_valid,
    input  logic [63:0]            imem_rsp_data,
    input  fe_ctrl_pkg::slot_cnt_t dec_credit,
    output logic                   dec_valid0,
    output fe_inst_pkg::inst_t     dec_inst0,
    output fe_inst_pkg::addr_t     dec_pc0,
    output logic                   dec_jal0,
    output fe_inst_pkg::addr_t     dec_target0,
    output logic                   dec_valid1,
    output fe_inst_pkg::inst_t     dec_inst1,
    output fe_inst_pkg::addr_t     dec_pc1,
    output logic                   dec_jal1,
    output fe_inst_pkg::addr_t     dec_target1
);

    fe_ctrl_pkg::fill_t     fill;
    fe_ctrl_pkg::slot_cnt_t push_cnt;
    fe_ctrl_pkg::slot_cnt_t pop_cnt;
    fe_inst_pkg::inst_t     push_inst0;
    fe_inst_pkg::inst_t     push_inst1;
    fe_inst_pkg::addr_t     push_pc0;
    fe_inst_pkg::addr_t     push_pc1;
    fe_inst_pkg::inst_t     head_inst0;
    fe_inst_pkg::inst_t     head_inst1;
    fe_inst_pkg::addr_t     head_pc0;
    fe_inst_pkg::addr_t     head_pc1;

    fetch_unit fetch_unit_i (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .imem_credit    (imem_credit),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_data  (imem_rsp_data),
        .fill           (fill),
        .push_cnt       (push_cnt),
        .push_inst0     (push_inst0),
        .push_inst1     (push_inst1),
        .push_pc0       (push_pc0),
        .push_pc1       (push_pc1)
    );

    fetch_buffer fetch_buffer_i (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_valid (redirect_valid),
        .push_cnt       (push_cnt),
        .push_inst0     (push_inst0),
        .push_inst1     (push_inst1),
        .push_pc0       (push_pc0),
        .push_pc1       (push_pc1),
        .pop_cnt        (pop_cnt),
        .head_inst0     (head_inst0),
        .head_inst1     (head_inst1),
        .head_pc0       (head_pc0),
        .head_pc1       (head_pc1),
        .fill           (fill)
    );

    issue_stage issue_stage_i (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_valid (redirect_valid),
        .head_inst0     (head_inst0),
        .head_inst1     (head_inst1),
        .head_pc0       (head_pc0),
        .head_pc1       (head_pc1),
        .fill           (fill),
        .dec_credit     (dec_credit),
        .pop_cnt        (pop_cnt),
        .dec_valid0     (dec_valid0),
        .dec_inst0      (dec_inst0),
        .dec_pc0        (dec_pc0),
        .dec_jal0       (dec_jal0),
        .dec_target0    (dec_target0),
        .dec_valid1     (dec_valid1),
        .dec_inst1      (dec_inst1),
        .dec_pc1        (dec_pc1),
        .dec_jal1       (dec_jal1),
        .dec_target1    (dec_target1)
    );

endmodule

//--- hw/fetch_unit.sv
`include "fe_consts.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   redirect_valid,
    input  fe_inst_pkg::addr_t     redirect_pc,
    output logic                   imem_req,
    output fe_inst_pkg::addr_t     imem_addr,
    input  logic                   imem_credit,
    input  logic                   imem_rsp_valid,
    input  logic [63:0]            imem_rsp_data,
    input  fe_ctrl_pkg::fill_t     fill,
    output fe_ctrl_pkg::slot_cnt_t push_cnt,
    output fe_inst_pkg::inst_t     push_inst0,
    output fe_inst_pkg::inst_t     push_inst1,
    output fe_inst_pkg::addr_t     push_pc0,
    output fe_inst_pkg::addr_t     push_pc1
);

    localparam int REQ_DEPTH = `FE_IMEM_CREDITS;

    fe_inst_pkg::addr_t    fetch_pc;
    fe_ctrl_pkg::credit_t  credits;
    fe_ctrl_pkg::credit_t  outstanding;
    fe_ctrl_pkg::credit_t  discard;
    fe_ctrl_pkg::req_ptr_t rec_wr;
    fe_ctrl_pkg::req_ptr_t rec_rd;
    fe_inst_pkg::addr_t    rec_addr [REQ_DEPTH];
    fe_inst_pkg::addr_t    rsp_addr;
    logic [5:0]            reserve;
    logic                  rsp_keep;

    // worst case occupancy once every pending response has landed
    assign reserve = 6'(fill) + 6'(push_cnt) + {2'b00, outstanding, 1'b0} + 6'd2;

    assign imem_req  = (credits != '0) && (reserve <= 6'(`FE_BUF_DEPTH)) && !redirect_valid;
    assign imem_addr = fetch_pc;
    assign rsp_addr  = rec_addr[rec_rd];
    assign rsp_keep  = imem_rsp_valid && (discard == '0) && !redirect_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_pc    <= `FE_RESET_PC;
            credits     <= fe_ctrl_pkg::credit_t'(`FE_IMEM_CREDITS);
            outstanding <= '0;
            discard     <= '0;
            rec_wr      <= '0;
            rec_rd      <= '0;
            push_cnt    <= '0;
        end else begin
            credits <= credits + fe_ctrl_pkg::credit_t'(imem_credit)
                       - fe_ctrl_pkg::credit_t'(imem_req);
            outstanding <= outstanding + fe_ctrl_pkg::credit_t'(imem_req)
                           - fe_ctrl_pkg::credit_t'(imem_rsp_valid);
            if (imem_req) begin
                rec_wr <= rec_wr + fe_ctrl_pkg::req_ptr_t'(1);
            end
            if (imem_rsp_valid) begin
                rec_rd <= rec_rd + fe_ctrl_pkg::req_ptr_t'(1);
            end
            if (redirect_valid) begin
                fetch_pc <= {redirect_pc[31:2], 2'b00};
                // a response arriving right now is dropped here already
                discard  <= outstanding - fe_ctrl_pkg::credit_t'(imem_rsp_valid);
            end else begin
                if (imem_req) begin
                    fetch_pc <= fetch_pc + (fetch_pc[2] ? 32'd4 : 32'd8);
                end
                if (imem_rsp_valid && (discard != '0)) begin
                    discard <= discard - fe_ctrl_pkg::credit_t'(1);
                end
            end
            if (rsp_keep) begin
                push_cnt <= rsp_addr[2] ? 2'd1 : 2'd2;
            end else begin
                push_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req) begin
            rec_addr[rec_wr] <= fetch_pc;
        end
        // odd word address uses only the upper half
        if (rsp_keep) begin
            push_inst0 <= rsp_addr[2] ? imem_rsp_data[63:32] : imem_rsp_data[31:0];
            push_inst1 <= imem_rsp_data[63:32];
            push_pc0   <= rsp_addr;
            push_pc1   <= rsp_addr + 32'd4;
        end
    end

endmodule

//--- hw/issue_stage.sv
`include "fe_consts.svh"

module issue_stage (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   redirect_valid,
    input  fe_inst_pkg::inst_t     head_inst0,
    input  fe_inst_pkg::inst_t     head_inst1,
    input  fe_inst_pkg::addr_t     head_pc0,
    input  fe_inst_pkg::addr_t     head_pc1,
    input  fe_ctrl_pkg::fill_t     fill,
    input  fe_ctrl_pkg::slot_cnt_t dec_credit,
    output fe_ctrl_pkg::slot_cnt_t pop_cnt,
    output logic                   dec_valid0,
    output fe_inst_pkg::inst_t     dec_inst0,
    output fe_inst_pkg::addr_t     dec_pc0,
    output logic                   dec_jal0,
    output fe_inst_pkg::addr_t     dec_target0,
    output logic                   dec_valid1,
    output fe_inst_pkg::inst_t     dec_inst1,
    output fe_inst_pkg::addr_t     dec_pc1,
    output logic                   dec_jal1,
    output fe_inst_pkg::addr_t     dec_target1
);

    fe_ctrl_pkg::credit_t   credits;
    fe_ctrl_pkg::slot_cnt_t by_credit;
    fe_ctrl_pkg::slot_cnt_t by_fill;

    function automatic logic is_jal(input fe_inst_pkg::inst_t inst);
        fe_inst_pkg::inst_u u;
        u = inst;
        return u.r_fmt.opcode == fe_inst_pkg::OPC_JAL;
    endfunction

    function automatic fe_inst_pkg::addr_t jal_target(input fe_inst_pkg::inst_t inst,
                                                      input fe_inst_pkg::addr_t pc);
        fe_inst_pkg::inst_u u;
        fe_inst_pkg::addr_t imm;
        u = inst;
        imm = {{12{u.j_fmt.imm20}}, u.j_fmt.imm19_12, u.j_fmt.imm11,
               u.j_fmt.imm10_1, 1'b0};
        return is_jal(inst) ? pc + imm : '0;
    endfunction

    assign by_credit = (credits >= 3'd2) ? 2'd2 : fe_ctrl_pkg::slot_cnt_t'(credits);
    assign by_fill   = (fill >= 5'd2) ? 2'd2 : fe_ctrl_pkg::slot_cnt_t'(fill);

    // nothing leaves the queue while it is being flushed
    assign pop_cnt = redirect_valid ? 2'd0 : ((by_fill < by_credit) ? by_fill : by_credit);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits    <= fe_ctrl_pkg::credit_t'(`FE_DEC_CREDITS);
            dec_valid0 <= 1'b0;
            dec_valid1 <= 1'b0;
        end else begin
            credits <= credits + fe_ctrl_pkg::credit_t'(dec_credit)
                       - fe_ctrl_pkg::credit_t'(pop_cnt);
            dec_valid0 <= (pop_cnt != 2'd0);
            dec_valid1 <= (pop_cnt == 2'd2);
        end
    end

    always_ff @(posedge clk) begin
        if (pop_cnt != 2'd0) begin
            dec_inst0   <= head_inst0;
            dec_pc0     <= head_pc0;
            dec_jal0    <= is_jal(head_inst0);
            dec_target0 <= jal_target(head_inst0, head_pc0);
            dec_inst1   <= head_inst1;
            dec_pc1     <= head_pc1;
            dec_jal1    <= is_jal(head_inst1);
            dec_target1 <= jal_target(head_inst1, head_pc1);
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# builds the fetch front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f vlog.f --top-module tb_fetch_frontend
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_fetch_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1

//--- tb/tb_fetch_frontend.sv
`include "fe_consts.svh"

module tb_fetch_frontend;

    localparam logic [6:0] JAL_OPCODE = 7'b1101111;

    logic                   clk;
    logic                   rstn;
    logic                   redirect_valid;
    fe_inst_pkg::addr_t     redirect_pc;
    logic                   imem_req;
    fe_inst_pkg::addr_t     imem_addr;
    logic                   imem_credit;
    logic                   imem_rsp_valid;
    logic [63:0]            imem_rsp_data;
    fe_ctrl_pkg::slot_cnt_t dec_credit;
    logic                   dec_valid0;
    fe_inst_pkg::inst_t     dec_inst0;
    fe_inst_pkg::addr_t     dec_pc0;
    logic                   dec_jal0;
    fe_inst_pkg::addr_t     dec_target0;
    logic                   dec_valid1;
    fe_inst_pkg::inst_t     dec_inst1;
    fe_inst_pkg::addr_t     dec_pc1;
    logic                   dec_jal1;
    fe_inst_pkg::addr_t     dec_target1;

    // memory model state
    fe_inst_pkg::addr_t rsp_addr_q [$];
    int                 rsp_due_q [$];
    int                 cycle;
    int                 mem_outstanding;
    int                 mem_credit_owed;

    // decode model and checker state
    int                 dec_owed;
    int                 dec_mode;
    int                 checked;
    fe_inst_pkg::addr_t exp_pc;

    fetch_frontend dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one word in eight is a jal
    function automatic logic is_jal_addr(input fe_inst_pkg::addr_t a);
        return a[4:2] == 3'd5;
    endfunction

    // jump offset of the jal stored at a
    function automatic logic [20:0] jal_offset(input fe_inst_pkg::addr_t a);
        return {a[22:3] ^ 20'h5a3c9, 1'b0};
    endfunction

    function automatic fe_inst_pkg::inst_t mem_word(input fe_inst_pkg::addr_t a);
        logic [20:0] imm;
        imm = jal_offset(a);
        if (is_jal_addr(a)) begin
            return {imm[20], imm[10:1], imm[11], imm[19:12], a[11:7], JAL_OPCODE};
        end
        return {a[31:7] ^ 25'h15ac3e1, 7'b0110011};
    endfunction

    function automatic void ref_model(input fe_inst_pkg::addr_t a,
                                      output fe_inst_pkg::inst_t word,
                                      output logic jal,
                                      output fe_inst_pkg::addr_t target);
        logic [20:0] imm;
        imm = jal_offset(a);
        word = mem_word(a);
        jal = is_jal_addr(a);
        target = jal ? a + {{11{imm[20]}}, imm} : 32'h0;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_inst(input fe_inst_pkg::inst_t got, input fe_inst_pkg::inst_t exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %08h expected %08h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_pc(input fe_inst_pkg::addr_t got, input fe_inst_pkg::addr_t exp,
                            input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %08h expected %08h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_target(input fe_inst_pkg::addr_t got, input fe_inst_pkg::addr_t exp,
                                input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %08h expected %08h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_jal(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_slot(input string slot, input fe_inst_pkg::inst_t inst,
                              input fe_inst_pkg::addr_t pc, input logic jal,
                              input fe_inst_pkg::addr_t target);
        fe_inst_pkg::inst_t exp_inst;
        logic               exp_jal;
        fe_inst_pkg::addr_t exp_target;
        ref_model(exp_pc, exp_inst, exp_jal, exp_target);
        check_pc(pc, exp_pc, {slot, " pc"});
        check_inst(inst, exp_inst, {slot, " inst"});
        check_jal(jal, exp_jal, {slot, " jal"});
        check_target(target, exp_target, {slot, " target"});
        exp_pc = exp_pc + 32'd4;
        checked++;
    endtask

    task automatic wait_for_slots(input int n, input int limit);
        int target;
        int cycles;
        target = checked + n;
        cycles = 0;
        while (checked < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                report_failure("timeout while waiting for instructions on the decode link");
            end
        end
    endtask

    task automatic wait_for_outstanding(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                report_failure("timeout while waiting for a pending memory response");
            end
        end while (rsp_addr_q.size() == 0);
    endtask

    // called on a rising edge
    task automatic send_redirect(input fe_inst_pkg::addr_t pc);
        #1;
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
    endtask

    // instruction memory answers in order after 1 to 6 cycles
    // each credit goes back some cycles after its data
    initial begin
        fe_inst_pkg::addr_t base;
        imem_credit     = 1'b0;
        imem_rsp_valid  = 1'b0;
        imem_rsp_data   = '0;
        cycle           = 0;
        mem_outstanding = 0;
        mem_credit_owed = 0;
        forever begin
            @(negedge clk);
            if (rstn && imem_req) begin
                if (mem_outstanding >= `FE_IMEM_CREDITS) begin
                    report_failure("memory request sent without a free credit");
                end
                if (imem_addr[1:0] != 2'b00) begin
                    report_failure("fetch address is not word aligned");
                end
                rsp_addr_q.push_back(imem_addr);
                rsp_due_q.push_back(cycle + int'($urandom_range(1, 6)));
                mem_outstanding++;
            end
            @(posedge clk);
            #1;
            cycle++;
            imem_credit    = 1'b0;
            imem_rsp_valid = 1'b0;
            if (mem_credit_owed > 0 && $urandom_range(0, 2) == 0) begin
                imem_credit = 1'b1;
                mem_credit_owed--;
                mem_outstanding--;
            end
            if (rsp_due_q.size() > 0 && cycle >= rsp_due_q[0]) begin
                base = rsp_addr_q.pop_front() & 32'hffff_fff8;
                void'(rsp_due_q.pop_front());
                imem_rsp_valid = 1'b1;
                imem_rsp_data  = {mem_word(base + 32'd4), mem_word(base)};
                mem_credit_owed++;
            end
        end
    end

    // decode credits return fast in mode 0 and slowly in mode 1
    // mode 2 holds every credit
    initial begin
        int ret;
        dec_credit = '0;
        dec_owed   = 0;
        forever begin
            @(negedge clk);
            dec_owed = dec_owed + int'(dec_valid0) + int'(dec_valid1);
            if (dec_owed > `FE_DEC_CREDITS) begin
                report_failure("more decode slots in flight than decode credits");
            end
            @(posedge clk);
            #1;
            ret = 0;
            if (dec_mode == 0 && $urandom_range(0, 3) != 0) begin
                ret = (dec_owed > 2) ? 2 : dec_owed;
            end else if (dec_mode == 1 && dec_owed > 0 && $urandom_range(0, 7) == 0) begin
                ret = 1;
            end
            dec_credit = fe_ctrl_pkg::slot_cnt_t'(ret);
            dec_owed   = dec_owed - ret;
        end
    end

    initial begin
        exp_pc  = `FE_RESET_PC;
        checked = 0;
        forever begin
            @(negedge clk);
            if (dec_valid1 && !dec_valid0) begin
                report_failure("decode slot 1 valid while slot 0 is idle");
            end
            if (dec_valid0) begin
                check_slot("slot0", dec_inst0, dec_pc0, dec_jal0, dec_target0);
            end
            if (dec_valid1) begin
                check_slot("slot1", dec_inst1, dec_pc1, dec_jal1, dec_target1);
            end
            // slots shown in the redirect cycle still belong to the old stream
            if (redirect_valid) begin
                exp_pc = redirect_pc;
            end
        end
    end

    initial begin
        fe_inst_pkg::addr_t pc;
        void'($urandom(32'h20f6));
        dec_mode       = 0;
        rstn           = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        wait_for_slots(60, 1000);

        // odd word start gives a single instruction first
        send_redirect(32'h0000_2004);
        wait_for_slots(40, 1000);

        dec_mode = 1;
        wait_for_slots(30, 3000);
        dec_mode = 2;
        repeat (200) @(posedge clk);
        dec_mode = 0;
        wait_for_slots(60, 1000);

        for (int i = 0; i < 8; i++) begin
            pc = 32'h0000_4000 + (fe_inst_pkg::addr_t'($urandom_range(0, 1023)) << 2);
            wait_for_outstanding(200);
            send_redirect(pc);
            wait_for_slots(10 + int'($urandom_range(0, 20)), 1000);
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/fe_inst_pkg.sv
hw/fe_ctrl_pkg.sv
hw/fetch_unit.sv
hw/fetch_buffer.sv
hw/issue_stage.sv
hw/fetch_frontend.sv
tb/tb_fetch_frontend.sv
